/* mul_params.svh */
/*
  Multiply unit widths
  Program counter, operand and sequence number sizes for the M-extension unit
*/

`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// Program counter width
`define MUL_ADDR_BITS 32

// Operand and result width
`define MUL_DATA_BITS 32

// Sequence number width
`define MUL_SEQ_BITS 5

`endif

/* mul_pkg.sv */
/*
  Multiply unit types
  Uop encoding, D and W stream messages, prepared operands and the product word
*/

`include "mul_params.svh"

package mul_pkg;

  // --------------------------------------------------
  // Uop encoding
  // --------------------------------------------------

  // The four M-extension multiplies
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_uop_e;

  // --------------------------------------------------
  // Stream messages
  // --------------------------------------------------

  // Decode to execute
  typedef struct packed {
    logic [`MUL_ADDR_BITS-1:0] pc;
    logic [`MUL_SEQ_BITS-1:0]  seq_num;
    logic [`MUL_DATA_BITS-1:0] op1;
    logic [`MUL_DATA_BITS-1:0] op2;
    logic [4:0]                waddr;
    mul_uop_e                  uop;
  } d_x_msg_t;

  // Execute to write-back
  typedef struct packed {
    logic [`MUL_ADDR_BITS-1:0] pc;
    logic [`MUL_SEQ_BITS-1:0]  seq_num;
    logic [4:0]                waddr;
    logic [`MUL_DATA_BITS-1:0] wdata;
    logic                      wen;
  } x_w_msg_t;

  // --------------------------------------------------
  // Datapath words
  // --------------------------------------------------

  // Operands after sign or zero extension, one bit wider than the data
  typedef struct packed {
    logic signed [`MUL_DATA_BITS:0] a;
    logic signed [`MUL_DATA_BITS:0] b;
  } mul_operand_t;

  // Product seen whole or as high and low halves
  typedef union packed {
    logic [2*`MUL_DATA_BITS-1:0] full;
    struct packed {
      logic [`MUL_DATA_BITS-1:0] hi;
      logic [`MUL_DATA_BITS-1:0] lo;
    } half;
  } mul_product_u;

endpackage

/* mul_operand_prep.sv */
/*
  Multiply operand preparation
  Decodes the uop and extends both operands to signed values one bit wider,
  so every multiply form runs on the same signed multiplier
*/

`timescale 1ns/1ns
`include "mul_params.svh"

module mul_operand_prep import mul_pkg::*; (
  input  d_x_msg_t     d_msg,
  output mul_operand_t operands
);

  // Extension mode per operand, high means sign extend
  logic op1_signed;
  logic op2_signed;

  // Top bits of each operand after extension
  logic op1_ext;
  logic op2_ext;

  // --------------------------------------------------
  // Uop decode
  // --------------------------------------------------

  always_comb begin
    op1_signed = 1'b1;
    op2_signed = 1'b1;
    case (d_msg.uop)
      // Signed by signed
      MUL, MULH: begin
        op1_signed = 1'b1;
        op2_signed = 1'b1;
      end
      // Signed op1, unsigned op2
      MULHSU: begin
        op1_signed = 1'b1;
        op2_signed = 1'b0;
      end
      // Unsigned by unsigned
      MULHU: begin
        op1_signed = 1'b0;
        op2_signed = 1'b0;
      end
      default: begin
        op1_signed = 1'b1;
        op2_signed = 1'b1;
      end
    endcase
  end

  // --------------------------------------------------
  // Extension
  // --------------------------------------------------

  // Copy of the sign bit, or zero for unsigned use
  assign op1_ext = op1_signed & d_msg.op1[`MUL_DATA_BITS-1];
  assign op2_ext = op2_signed & d_msg.op2[`MUL_DATA_BITS-1];

  // The extra bit keeps unsigned values positive in signed math
  assign operands.a = {op1_ext, d_msg.op1};
  assign operands.b = {op2_ext, d_msg.op2};

endmodule

/* mul_pipe.sv */
/*
  Multiply pipeline
  Three stages of operand register, product and result select, with one
  shared advance signal that stalls the whole pipe under W back-pressure
*/

`timescale 1ns/1ns
`include "mul_params.svh"

module mul_pipe import mul_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  d_x_msg_t     in_msg,
  input  mul_operand_t operands,
  input  logic         in_val,
  output logic         in_rdy,
  output x_w_msg_t     w_msg,
  output logic         w_val,
  input  logic         w_rdy
);

  // Fields that ride along with each operation
  typedef struct packed {
    logic [`MUL_ADDR_BITS-1:0] pc;
    logic [`MUL_SEQ_BITS-1:0]  seq_num;
    logic [4:0]                waddr;
    mul_uop_e                  uop;
  } stage_meta_t;

  // --------------------------------------------------
  // Declarations
  // --------------------------------------------------

  // Whole pipe moves together or holds together
  logic advance;

  // Stage valids
  logic s1_val;
  logic s2_val;
  logic s3_val;

  // Per-stage load enables
  logic s1_load;
  logic s2_load;
  logic s3_load;

  // Stage one payload
  stage_meta_t  s1_meta;
  mul_operand_t s1_operands;

  // Full signed product, two bits wider than the kept word
  logic signed [2*`MUL_DATA_BITS+1:0] s1_full_product;

  // Stage two payload
  stage_meta_t  s2_meta;
  mul_product_u s2_product;

  // Stage three payload and its next value
  x_w_msg_t s3_next;
  x_w_msg_t s3_msg;

  // --------------------------------------------------
  // Stall control
  // --------------------------------------------------

  // Move when the last stage is empty or is being drained
  assign advance = ~s3_val | w_rdy;
  assign in_rdy  = advance;

  // Payload loads only on a real operation
  assign s1_load = advance & in_val;
  assign s2_load = advance & s1_val;
  assign s3_load = advance & s2_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
      s3_val <= 1'b0;
    end else if (advance) begin
      // Bubbles shift through like operations
      s1_val <= in_val;
      s2_val <= s1_val;
      s3_val <= s2_val;
    end
  end

  // --------------------------------------------------
  // Stage one, operand register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (s1_load) begin
      s1_operands     <= operands;
      s1_meta.pc      <= in_msg.pc;
      s1_meta.seq_num <= in_msg.seq_num;
      s1_meta.waddr   <= in_msg.waddr;
      s1_meta.uop     <= in_msg.uop;
    end
  end

  // --------------------------------------------------
  // Stage two, product
  // --------------------------------------------------

  // One signed multiplier covers all four forms
  assign s1_full_product = s1_operands.a * s1_operands.b;

  always_ff @(posedge clk) begin
    if (s2_load) begin
      // Top two bits are pure extension and are dropped
      s2_product.full <= s1_full_product[2*`MUL_DATA_BITS-1:0];
      s2_meta         <= s1_meta;
    end
  end

  // --------------------------------------------------
  // Stage three, result select and W message
  // --------------------------------------------------

  always_comb begin
    s3_next.pc      = s2_meta.pc;
    s3_next.seq_num = s2_meta.seq_num;
    s3_next.waddr   = s2_meta.waddr;
    // Low half for MUL, high half for the rest
    if (s2_meta.uop == MUL) begin
      s3_next.wdata = s2_product.half.lo;
    end else begin
      s3_next.wdata = s2_product.half.hi;
    end
    // Writes to x0 are dropped
    s3_next.wen     = |s2_meta.waddr;
  end

  always_ff @(posedge clk) begin
    if (s3_load) begin
      s3_msg <= s3_next;
    end
  end

  // Result is ready for the W transfer on the third edge after acceptance
  assign w_msg = s3_msg;
  assign w_val = s3_val;

endmodule

/* mul_unit.sv */
/*
  Multiply execute unit
  Takes D stream operations, runs MUL, MULH, MULHSU and MULHU, and returns
  write-back messages on the W stream
*/

`timescale 1ns/1ns
`include "mul_params.svh"

module mul_unit import mul_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  d_x_msg_t d_msg,
  input  logic     d_val,
  output logic     d_rdy,
  output x_w_msg_t w_msg,
  output logic     w_val,
  input  logic     w_rdy
);

  // Extended operands, same cycle as d_msg
  mul_operand_t operands;

  // --------------------------------------------------
  // Operand preparation
  // --------------------------------------------------

  mul_operand_prep mul_operand_prep_i (
    .d_msg    (d_msg),
    .operands (operands)
  );

  // --------------------------------------------------
  // Pipeline
  // --------------------------------------------------

  mul_pipe mul_pipe_i (
    .clk      (clk),
    .reset    (reset),
    .in_msg   (d_msg),
    .operands (operands),
    .in_val   (d_val),
    .in_rdy   (d_rdy),
    .w_msg    (w_msg),
    .w_val    (w_val),
    .w_rdy    (w_rdy)
  );

endmodule

/* tb_clock_gen.sv */
/*
  Testbench clock and reset source
  Free-running clock and a synchronous reset held for a fixed number of cycles
*/

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Released just after an edge, like every other driven input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

/* mul_unit_sva.sv */
/*
  Multiply unit stream checks
  Concurrent assertions on the W stream and on d_rdy, bound into mul_unit
*/

`timescale 1ns/1ns

module mul_unit_sva import mul_pkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     d_rdy,
  input x_w_msg_t w_msg,
  input logic     w_val,
  input logic     w_rdy
);

  // --------------------------------------------------
  // Reset
  // --------------------------------------------------

  // Any reset cycle leaves the last stage empty
  w_val_low_in_reset: assert property (@(posedge clk) reset |=> !w_val)
    else $error("w_val high on the cycle after a reset cycle");

  // --------------------------------------------------
  // W stream hold
  // --------------------------------------------------

  // Stalled result stays offered and unchanged
  w_msg_held: assert property (@(posedge clk) disable iff (reset)
    (w_val && !w_rdy) |=> (w_val && $stable(w_msg)))
    else $error("W message dropped or changed while stalled");

  // --------------------------------------------------
  // Input ready
  // --------------------------------------------------

  // Ready exactly when the pipe can advance, so high whenever w_rdy is high
  d_rdy_with_w_rdy: assert property (@(posedge clk) disable iff (reset)
    d_rdy == (!w_val || w_rdy))
    else $error("d_rdy does not follow the pipe advance condition");

endmodule

bind mul_unit mul_unit_sva mul_unit_sva_i (
  .clk   (clk),
  .reset (reset),
  .d_rdy (d_rdy),
  .w_msg (w_msg),
  .w_val (w_val),
  .w_rdy (w_rdy)
);

/* mul_unit_tb.sv */
/*
  Multiply unit testbench
  Table of corner and random operations, reference results, random W
  back-pressure, in-order checking and a watchdog
*/

`timescale 1ns/1ns
`include "mul_params.svh"

module mul_unit_tb import mul_pkg::*; ();

  localparam int W            = `MUL_DATA_BITS;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int N_CORNER     = 15;
  localparam int N_ROWS       = 40;
  localparam int PC_BASE      = 'h1000;
  // Pipeline depth plus one
  localparam int DRAIN_CYCLES = 4;
  // 20 cycles per row on top of reset
  localparam int TIMEOUT_NS   = (N_ROWS * 20 + RESET_CYCLES) * CLK_PERIOD;

  logic     clk;
  logic     reset;
  d_x_msg_t d_msg;
  logic     d_val;
  logic     d_rdy;
  x_w_msg_t w_msg;
  logic     w_val;
  logic     w_rdy;

  // Stimulus table and expected results
  string          row_name  [N_ROWS];
  mul_uop_e       row_uop   [N_ROWS];
  logic [W-1:0]   row_op1   [N_ROWS];
  logic [W-1:0]   row_op2   [N_ROWS];
  logic [4:0]     row_waddr [N_ROWS];
  logic [W-1:0]   row_wdata [N_ROWS];

  // Row indices in the order the unit accepted them
  int          sent_q[$];
  int          received   = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  logic [15:0] lfsr_state = 16'd81;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  mul_unit mul_unit_i (
    .clk   (clk),
    .reset (reset),
    .d_msg (d_msg),
    .d_val (d_val),
    .d_rdy (d_rdy),
    .w_msg (w_msg),
    .w_val (w_val),
    .w_rdy (w_rdy)
  );

  // --------------------------------------------------
  // Random bits and reference model
  // --------------------------------------------------

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] r;
    int          k;
    r = '0;
    for (k = 0; k < n; k++) begin
      r          = {r[62:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  // Extend both operands to full product width and keep the lo or hi half
  function automatic logic [W-1:0] ref_result(input mul_uop_e uop,
                                             input logic [W-1:0] op1,
                                             input logic [W-1:0] op2);
    logic [2*W-1:0] x;
    logic [2*W-1:0] y;
    logic [2*W-1:0] p;
    logic           x_signed;
    logic           y_signed;
    x_signed = (uop != MULHU);
    y_signed = (uop == MUL) || (uop == MULH);
    x = x_signed ? {{W{op1[W-1]}}, op1} : {{W{1'b0}}, op1};
    y = y_signed ? {{W{op2[W-1]}}, op2} : {{W{1'b0}}, op2};
    p = x * y;
    return (uop == MUL) ? p[W-1:0] : p[2*W-1:W];
  endfunction

  // --------------------------------------------------
  // Table and messages
  // --------------------------------------------------

  function automatic void set_row(input int i, input string name, input mul_uop_e uop,
                                  input logic [W-1:0] op1, input logic [W-1:0] op2,
                                  input logic [4:0] waddr);
    row_name[i]  = name;
    row_uop[i]   = uop;
    row_op1[i]   = op1;
    row_op2[i]   = op2;
    row_waddr[i] = waddr;
    row_wdata[i] = ref_result(uop, op1, op2);
  endfunction

  task automatic build_table();
    int i;
    // Corner rows of zero, one, minus one, most negative and max unsigned
    set_row(0,  "mul_zero",           MUL,    32'h0,        32'h12345678, 5'd1);
    set_row(1,  "mul_one",            MUL,    32'h1,        32'h87654321, 5'd2);
    set_row(2,  "mul_neg1",           MUL,    32'hffffffff, 32'h7,        5'd3);
    set_row(3,  "mul_minneg_neg1",    MUL,    32'h80000000, 32'hffffffff, 5'd4);
    set_row(4,  "mul_maxu_sq",        MUL,    32'hffffffff, 32'hffffffff, 5'd5);
    set_row(5,  "mulh_neg1_minneg",   MULH,   32'hffffffff, 32'h80000000, 5'd6);
    set_row(6,  "mulh_minneg_sq",     MULH,   32'h80000000, 32'h80000000, 5'd7);
    set_row(7,  "mulh_neg1_one",      MULH,   32'hffffffff, 32'h1,        5'd8);
    set_row(8,  "mulhsu_neg1_maxu",   MULHSU, 32'hffffffff, 32'hffffffff, 5'd9);
    set_row(9,  "mulhsu_minneg_maxu", MULHSU, 32'h80000000, 32'hffffffff, 5'd10);
    set_row(10, "mulhsu_one_maxu",    MULHSU, 32'h1,        32'hffffffff, 5'd11);
    set_row(11, "mulhu_maxu_sq",      MULHU,  32'hffffffff, 32'hffffffff, 5'd12);
    set_row(12, "mulhu_minneg_two",   MULHU,  32'h80000000, 32'h2,        5'd13);
    // Writes to x0 must clear wen
    set_row(13, "mulhu_x0",           MULHU,  32'h0,        32'hffffffff, 5'd0);
    set_row(14, "mul_x0",             MUL,    32'h3,        32'h5,        5'd0);
    for (i = N_CORNER; i < N_ROWS; i++) begin
      set_row(i, $sformatf("rand_%0d", i), mul_uop_e'(2'(random_bits(2))),
              W'(random_bits(W)), W'(random_bits(W)), 5'(random_bits(5)));
    end
  endtask

  function automatic d_x_msg_t make_msg(input int i);
    d_x_msg_t m;
    m.pc      = `MUL_ADDR_BITS'(PC_BASE + 4 * i);
    m.seq_num = `MUL_SEQ_BITS'(i);
    m.op1     = row_op1[i];
    m.op2     = row_op2[i];
    m.waddr   = row_waddr[i];
    m.uop     = row_uop[i];
    return m;
  endfunction

  function automatic x_w_msg_t expected_msg(input int i);
    x_w_msg_t e;
    e.pc      = `MUL_ADDR_BITS'(PC_BASE + 4 * i);
    e.seq_num = `MUL_SEQ_BITS'(i);
    e.waddr   = row_waddr[i];
    e.wdata   = row_wdata[i];
    e.wen     = (row_waddr[i] != 5'd0);
    return e;
  endfunction

  function automatic string fmt_msg(input x_w_msg_t m);
    return $sformatf("pc=%h seq=%0d waddr=%0d wdata=%h wen=%b",
                     m.pc, m.seq_num, m.waddr, m.wdata, m.wen);
  endfunction

  // --------------------------------------------------
  // D stream driver
  // --------------------------------------------------

  // Starts 1 ns after an edge and returns 1 ns after the accepting edge
  task automatic send_op(input int i);
    logic accepted;
    d_msg    = make_msg(i);
    d_val    = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      #1;
      accepted = d_rdy;
      if (accepted) begin
        sent_q.push_back(i);
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial begin : drive
    int i;
    d_msg = '0;
    d_val = 1'b0;
    w_rdy = 1'b0;
    build_table();
    @(negedge reset);
    @(posedge clk);
    #1;
    for (i = 0; i < N_ROWS; i++) begin
      send_op(i);
    end
    d_val = 1'b0;
    d_msg = '0;
    wait (received == N_ROWS);
    // Pipe must stay empty once every result is out
    repeat (DRAIN_CYCLES) begin
      @(posedge clk);
      #2;
      assert (!w_val) else begin
        $display("An extra result came out after the last expected one");
        fail_count++;
      end
    end
    $display("Results: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // --------------------------------------------------
  // W stream receiver and checker
  // --------------------------------------------------

  initial begin : receive
    int       i;
    x_w_msg_t exp;
    while (received < N_ROWS) begin
      @(posedge clk);
      #1 w_rdy = random_bits(1) != 0;
      // Outputs have settled by mid-cycle
      #1;
      if (reset) begin
        assert (!w_val) else begin
          $display("w_val went high while reset was held");
          fail_count++;
        end
      end else if (w_val && w_rdy) begin
        if (sent_q.size() == 0) begin
          $display("A result came out with no operation outstanding");
          fail_count++;
          received++;
        end else begin
          i   = sent_q.pop_front();
          exp = expected_msg(i);
          assert (w_msg === exp) begin
            $display("ok %s", row_name[i]);
            pass_count++;
          end else begin
            $display("Mismatch %s: expected %s, actual %s",
                     row_name[i], fmt_msg(exp), fmt_msg(w_msg));
            fail_count++;
          end
          received++;
        end
      end
    end
    // Keep w_rdy up through the edge that takes the last result
    @(posedge clk);
    #1 w_rdy = 1'b0;
  end

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the unit stopped producing results, %0d of %0d received",
             received, N_ROWS);
    $display("Test failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
mul_pkg.sv
mul_operand_prep.sv
mul_pipe.sv
mul_unit.sv
tb_clock_gen.sv
mul_unit_sva.sv
mul_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the multiply unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module mul_unit_tb \
  -f vlog.f \
  -o mul_unit_sim

./obj_dir/mul_unit_sim | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished, see sim.log"
